//--- Makefile
# Verilator build, run and lint for the word-level link

VERILATOR  ?= verilator
TOP        ?= tb_serdes_link
RTL_TOP    ?= serdes_link_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= === PASS ===
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only

SRCS     := $(filter %.sv,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter logic/%.sv,$(SRCS))
HDRS     := $(wildcard logic/*.svh)
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit status
run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+logic $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/lane_slipper.sv
`default_nettype none

`include "link_defs.svh"

// Word-level bit-slip window for one receive lane
module lane_slipper (
    input  wire logic                 txclk_div,
    input  wire logic                 rst,
    input  wire logic                 slip_i,         // One-cycle slip strobe
    input  wire link_pkg::line_word_t raw_word_i,     // Raw word, one per cycle
    output link_pkg::line_word_t      aligned_word_o  // Registered aligned window
);

    //////////////////////////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////////////////////////

    link_pkg::line_word_t prev_q;       // Raw word from the last cycle
    link_pkg::slip_ofs_t  ofs_q;        // Current slip offset k
    link_pkg::line_word_t aligned_q;    // Output stage

    logic [2*`LINK_WORD_W-1:0] pair;     // {previous, current} raw words
    logic [2*`LINK_WORD_W-1:0] pair_sh;  // Pair after the left shift by k

    assign pair    = {prev_q, raw_word_i};
    assign pair_sh = pair << ofs_q;

    //////////////////////////////////////////////////////////////////////
    // Offset counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            ofs_q <= '0;
        end else if (slip_i) begin
            ofs_q <= ofs_q + 1'b1;           // Wraps from 7 back to 0
        end
    end

    // Previous raw word, reloaded every cycle
    always_ff @(posedge txclk_div) begin
        prev_q <= raw_word_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Window register
    //////////////////////////////////////////////////////////////////////

    // Upper half of the shifted pair is the aligned word
    // One register, so a word sampled at edge N shows after edge N+1
    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            aligned_q <= '0;
        end else begin
            aligned_q <= pair_sh[2*`LINK_WORD_W-1:`LINK_WORD_W];  // Offset held since last edge
        end
    end

    assign aligned_word_o = aligned_q;

endmodule

`default_nettype wire

//--- logic/link_defs.svh
`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Line word and bit-slip geometry
//////////////////////////////////////////////////////////////////////

`define LINK_WORD_W         8        // Bits per line word
`define LINK_TRAIN_PATTERN  8'hC3    // Clock lane training word, marks alignment
`define LINK_SLIP_W         3        // Slip offset width, covers 0..7
`define LINK_SLIP_WAIT      3        // Quiet cycles after each slip pulse

//////////////////////////////////////////////////////////////////////
// SD frame field positions inside a line word
//////////////////////////////////////////////////////////////////////

// Bit 7 carries nothing and is sent as zero
`define SD_FRM_CMD          0        // Command bit
`define SD_FRM_CMD_T        1        // Command enable
`define SD_FRM_DAT_T        2        // Data enable
`define SD_FRM_DAT_LSB      3        // Data bits 3..0 sit at word bits 6..3

`endif

//--- logic/link_pkg.sv
`default_nettype none

`include "link_defs.svh"

// Types shared by the line side of the link
package link_pkg;

    // One raw or aligned line word
    typedef logic [`LINK_WORD_W-1:0] line_word_t;

    // Bit-slip offset, wraps modulo the word width
    typedef logic [`LINK_SLIP_W-1:0] slip_ofs_t;

    // Aligner sequence: one pulse state, then the quiet waits
    // Encoding width follows the number of states in one slip round
    typedef enum logic [$clog2(`LINK_SLIP_WAIT+1)-1:0] {
        ALIGN_SLIP,     // Pulse slip if training word mismatches
        ALIGN_WAIT1,    // Drop pulse, slipper takes the new offset
        ALIGN_WAIT2,    // Window register refills
        ALIGN_WAIT3     // Aligned word refills, compare next cycle
    } align_state_t;

endpackage

`default_nettype wire

//--- logic/sd_bridge.sv
`default_nettype none

`include "link_defs.svh"

// SD side of the link
// Packs SD inputs into a transmit frame, unpacks the received frame
module sd_bridge (
    input  wire logic                 txclk_div,
    input  wire logic                 rst,
    input  wire logic                 sd_cmd_i,     // SD command in
    input  wire sd_pkg::sd_nibble_t   sd_dat_i,     // SD data in
    input  wire link_pkg::line_word_t rx_frame_i,   // Aligned data lane word
    input  wire link_pkg::line_word_t echo_word_i,  // Aligned clock lane word
    output link_pkg::line_word_t      tx_frame_o,   // Packed transmit frame
    output link_pkg::line_word_t      tx_echo_o,    // Clock lane echo
    output logic                      sd_cmd_o,
    output logic                      sd_cmd_t_o,
    output sd_pkg::sd_nibble_t        sd_dat_o,
    output logic                      sd_dat_t_o
);

    link_pkg::line_word_t tx_next;   // Frame built from the SD inputs

    //////////////////////////////////////////////////////////////////////
    // Transmit packing
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        tx_next                                                  = '0;  // Bit 7 stays zero
        tx_next[`SD_FRM_CMD]                                     = sd_cmd_i;
        tx_next[`SD_FRM_DAT_LSB +: $bits(sd_pkg::sd_nibble_t)]   = sd_dat_i;
        // Enable bits only have meaning on the receive side
    end

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            tx_frame_o <= '0;
            tx_echo_o  <= '0;
        end else begin
            tx_frame_o <= tx_next;
            tx_echo_o  <= echo_word_i;      // Training word back to the far end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Receive unpacking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            sd_cmd_o   <= 1'b0;
            sd_cmd_t_o <= 1'b0;
            sd_dat_o   <= '0;
            sd_dat_t_o <= 1'b0;
        end else begin
            sd_cmd_o   <= rx_frame_i[`SD_FRM_CMD];
            sd_cmd_t_o <= rx_frame_i[`SD_FRM_CMD_T];
            sd_dat_o   <= rx_frame_i[`SD_FRM_DAT_LSB +: $bits(sd_pkg::sd_nibble_t)];
            sd_dat_t_o <= rx_frame_i[`SD_FRM_DAT_T];
        end
    end

endmodule

`default_nettype wire

//--- logic/sd_pkg.sv
`default_nettype none

// Types for the SD bus fields carried inside a line frame
package sd_pkg;

    // Four SD data lines, DAT3..DAT0
    // Upper DAT lines of an 8-bit bus are not carried over the link
    typedef logic [3:0] sd_nibble_t;

endpackage

`default_nettype wire

//--- logic/serdes_link_top.sv
`default_nettype none

// Word-level link top
// Two receive lanes share one slip offset driven by the aligner
module serdes_link_top (
    input  wire logic                 txclk_div,
    input  wire logic                 rst,

    // Receive line words
    input  wire link_pkg::line_word_t rx_clk_word_i,   // Clock lane, training pattern
    input  wire link_pkg::line_word_t rx_data_word_i,  // Data lane, SD frames

    // SD inputs toward the far end
    input  wire logic                 sd_cmd_i,
    input  wire sd_pkg::sd_nibble_t   sd_dat_i,

    // Transmit line words
    output link_pkg::line_word_t      tx_clk_word_o,   // Echoed clock lane
    output link_pkg::line_word_t      tx_data_word_o,  // Packed SD frame

    output logic                      locked_o,

    // Unpacked SD outputs
    output logic                      sd_cmd_o,
    output logic                      sd_cmd_t_o,
    output sd_pkg::sd_nibble_t        sd_dat_o,
    output logic                      sd_dat_t_o
);

    //////////////////////////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////////////////////////

    logic                 slip_pulse;      // Common slip strobe, keeps lanes in step
    link_pkg::line_word_t clk_aligned;     // To aligner and echo
    link_pkg::line_word_t dat_aligned;     // To bridge unpacking

    // Clock lane
    lane_slipper u_clk_slip (
        .txclk_div      (txclk_div),
        .rst            (rst),
        .slip_i         (slip_pulse),
        .raw_word_i     (rx_clk_word_i),
        .aligned_word_o (clk_aligned)
    );

    // Data lane
    lane_slipper u_dat_slip (
        .txclk_div      (txclk_div),
        .rst            (rst),
        .slip_i         (slip_pulse),
        .raw_word_i     (rx_data_word_i),
        .aligned_word_o (dat_aligned)
    );

    word_aligner u_aligner (
        .txclk_div      (txclk_div),
        .rst            (rst),
        .train_word_i   (clk_aligned),
        .slip_o         (slip_pulse),
        .locked_o       (locked_o)     // Status only, data is not gated
    );

    sd_bridge u_bridge (
        .txclk_div      (txclk_div),
        .rst            (rst),
        .sd_cmd_i       (sd_cmd_i),
        .sd_dat_i       (sd_dat_i),
        .rx_frame_i     (dat_aligned),
        .echo_word_i    (clk_aligned),
        .tx_frame_o     (tx_data_word_o),
        .tx_echo_o      (tx_clk_word_o),
        .sd_cmd_o       (sd_cmd_o),
        .sd_cmd_t_o     (sd_cmd_t_o),
        .sd_dat_o       (sd_dat_o),
        .sd_dat_t_o     (sd_dat_t_o)
    );

endmodule

`default_nettype wire

//--- logic/word_aligner.sv
`default_nettype none

`include "link_defs.svh"

// Training pattern search on the clock lane
// Slips both lanes until the pattern shows, then holds lock
module word_aligner (
    input  wire logic                 txclk_div,
    input  wire logic                 rst,
    input  wire link_pkg::line_word_t train_word_i,  // Aligned clock lane word
    output logic                      slip_o,        // Slip strobe to both slippers
    output logic                      locked_o       // Sticky lock flag
);

    //////////////////////////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////////////////////////

    link_pkg::align_state_t state_q;
    logic                   slip_q;
    logic                   locked_q;
    logic                   train_match;   // Window shows the training word

    assign train_match = (train_word_i == `LINK_TRAIN_PATTERN);

    //////////////////////////////////////////////////////////////////////
    // Slip sequencer
    //////////////////////////////////////////////////////////////////////

    // One pulse then three quiet cycles per round
    // The quiet cycles let the new offset ripple through the slipper
    // pipeline before the next compare in ALIGN_SLIP
    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            state_q  <= link_pkg::ALIGN_SLIP;
            slip_q   <= 1'b0;
            locked_q <= 1'b0;
        end else if (locked_q) begin
            slip_q <= 1'b0;                      // Locked, offset frozen
        end else if (train_match) begin
            locked_q <= 1'b1;                    // First match sets lock
            slip_q   <= 1'b0;
        end else begin
            case (state_q)
                link_pkg::ALIGN_SLIP: begin
                    slip_q  <= 1'b1;             // Request one bit of slip
                    state_q <= link_pkg::ALIGN_WAIT1;
                end
                link_pkg::ALIGN_WAIT1: begin
                    slip_q  <= 1'b0;             // Strobe lasts one cycle
                    state_q <= link_pkg::ALIGN_WAIT2;
                end
                link_pkg::ALIGN_WAIT2: begin
                    slip_q  <= 1'b0;
                    state_q <= link_pkg::ALIGN_WAIT3;
                end
                link_pkg::ALIGN_WAIT3: begin
                    slip_q  <= 1'b0;
                    state_q <= link_pkg::ALIGN_SLIP;   // Compare fresh window next
                end
                default: begin
                    slip_q  <= 1'b0;
                    state_q <= link_pkg::ALIGN_SLIP;
                end
            endcase
        end
    end

    assign slip_o   = slip_q;
    assign locked_o = locked_q;

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/link_pkg.sv
logic/sd_pkg.sv
logic/lane_slipper.sv
logic/word_aligner.sv
logic/sd_bridge.sv
logic/serdes_link_top.sv
tb/tb_serdes_link.sv

//--- tb/tb_serdes_link.sv
`default_nettype none

`include "link_defs.svh"

module tb_serdes_link;

    //////////////////////////////////////////////////////////////////////
    // Run parameters
    //////////////////////////////////////////////////////////////////////

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 8;
    localparam int          LOCK_BOUND   = 40;   // Cycles from release to locked_o
    localparam int          DATA_LAT     = 3;    // Word pair fill, aligned, bridge
    localparam int          HOLD_CYCLES  = 6;    // Stability window per data word
    localparam int          ECHO_CYCLES  = 4;
    localparam int          DATA_WORDS   = 3;
    localparam int          PACK_VECTORS = 16;
    localparam int          STICKY_WORDS = 12;
    localparam logic [31:0] RNG_SEED     = 32'h98f5_103d;

    // Worst-case length of each test in cycles
    localparam int RESET_TEST  = 1 + RESET_CYCLES + 2;
    localparam int PACK_TEST   = PACK_VECTORS + 1;
    localparam int LOCK_TEST   = 1 + RESET_CYCLES + LOCK_BOUND;
    localparam int ROT_TEST    = LOCK_TEST + 2 + ECHO_CYCLES
                               + DATA_WORDS * (DATA_LAT + HOLD_CYCLES);
    localparam int STICKY_TEST = LOCK_TEST + STICKY_WORDS + DATA_LAT;
    localparam int WATCHDOG_CYCLES = RESET_TEST + PACK_TEST + 8 * ROT_TEST
                                   + STICKY_TEST + 100;   // 100 cycles of slack

    logic                 txclk_div;
    logic                 rst;
    link_pkg::line_word_t rx_clk_word_i;
    link_pkg::line_word_t rx_data_word_i;
    logic                 sd_cmd_i;
    sd_pkg::sd_nibble_t   sd_dat_i;
    link_pkg::line_word_t tx_clk_word_o;
    link_pkg::line_word_t tx_data_word_o;
    logic                 locked_o;
    logic                 sd_cmd_o;
    logic                 sd_cmd_t_o;
    sd_pkg::sd_nibble_t   sd_dat_o;
    logic                 sd_dat_t_o;

    int error_count;
    int check_count;

    serdes_link_top dut0 (
        .txclk_div      (txclk_div),
        .rst            (rst),
        .rx_clk_word_i  (rx_clk_word_i),
        .rx_data_word_i (rx_data_word_i),
        .sd_cmd_i       (sd_cmd_i),
        .sd_dat_i       (sd_dat_i),
        .tx_clk_word_o  (tx_clk_word_o),
        .tx_data_word_o (tx_data_word_o),
        .locked_o       (locked_o),
        .sd_cmd_o       (sd_cmd_o),
        .sd_cmd_t_o     (sd_cmd_t_o),
        .sd_dat_o       (sd_dat_o),
        .sd_dat_t_o     (sd_dat_t_o)
    );

    always #(CLK_PERIOD / 2) txclk_div = ~txclk_div;

    //////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////////////////////////

    // Upper byte of {prev, cur} shifted left by k
    function automatic logic [7:0] slip_window(logic [7:0] prev, logic [7:0] cur, int k);
        logic [15:0] pair;
        pair = {prev, cur} << k;
        return pair[15:8];
    endfunction

    // Constant stream, so the window is a plain rotation
    function automatic logic [7:0] rotate_left(logic [7:0] w, int n);
        return slip_window(w, w, n);
    endfunction

    // No enable inputs on the transmit side, bits 1, 2 and 7 stay zero
    function automatic logic [7:0] expected_frame(logic cmd, logic [3:0] dat);
        logic [7:0] f;
        f                         = 8'h00;
        f[`SD_FRM_CMD]            = cmd;
        f[`SD_FRM_DAT_LSB +: 4]   = dat;
        return f;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got 8'h%02h, expected 8'h%02h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at t=%0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic drive_idle();
        rx_clk_word_i  = '0;
        rx_data_word_i = '0;
        sd_cmd_i       = 1'b0;
        sd_dat_i       = '0;
    endtask

    // Ends on the falling edge where rst is released
    task automatic reset_dut();
        @(negedge txclk_div);
        rst = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(negedge txclk_div);
        rst = 1'b1;
    endtask

    task automatic check_outputs_zero();
        check_value("locked_o",       8'(locked_o),   8'h00);
        check_value("tx_clk_word_o",  tx_clk_word_o,  8'h00);
        check_value("tx_data_word_o", tx_data_word_o, 8'h00);
        check_value("sd_cmd_o",       8'(sd_cmd_o),   8'h00);
        check_value("sd_cmd_t_o",     8'(sd_cmd_t_o), 8'h00);
        check_value("sd_dat_o",       8'(sd_dat_o),   8'h00);
        check_value("sd_dat_t_o",     8'(sd_dat_t_o), 8'h00);
    endtask

    // Training word rotated by r on the clock lane, wait for locked_o
    task automatic lock_link(input int r, output bit ok);
        int waited;
        reset_dut();
        @(negedge txclk_div);                // Lane idle for one cycle after release
        rx_clk_word_i = rotate_left(`LINK_TRAIN_PATTERN, r);
        waited        = 1;
        ok            = 1'b0;
        while (!ok && waited < LOCK_BOUND) begin
            @(negedge txclk_div);
            waited++;
            if (locked_o === 1'b1)
                ok = 1'b1;
        end
        if (!ok)
            report_failure($sformatf("locked_o did not rise within %0d cycles, rotation %0d",
                                     LOCK_BOUND, r));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        int i;
        @(negedge txclk_div);
        rst = 1'b0;
        drive_idle();
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(negedge txclk_div);
            check_outputs_zero();            // Held in reset
        end
        rst = 1'b1;
        repeat (2) begin
            @(negedge txclk_div);
            check_outputs_zero();            // Idle inputs right after release
        end
    endtask

    task automatic test_frame_packing();
        int          i;
        logic [31:0] r;
        for (i = 0; i < PACK_VECTORS; i++) begin
            r        = $urandom;
            sd_cmd_i = r[0];
            sd_dat_i = r[4:1];
            @(negedge txclk_div);            // One edge to the packed frame
            check_value("tx_data_word_o", tx_data_word_o, expected_frame(r[0], r[4:1]));
        end
        sd_cmd_i = 1'b0;
        sd_dat_i = '0;
    endtask

    // Data words rotated by the same r come out straight once locked
    task automatic test_data_alignment(input int r);
        int         w;
        int         h;
        logic [7:0] x;
        for (w = 0; w < DATA_WORDS; w++) begin
            x              = rand_byte();
            rx_data_word_i = rotate_left(x, r);
            repeat (DATA_LAT) @(negedge txclk_div);
            for (h = 0; h < HOLD_CYCLES; h++) begin
                check_value("sd_cmd_o",   8'(sd_cmd_o),   8'(x[`SD_FRM_CMD]));
                check_value("sd_cmd_t_o", 8'(sd_cmd_t_o), 8'(x[`SD_FRM_CMD_T]));
                check_value("sd_dat_t_o", 8'(sd_dat_t_o), 8'(x[`SD_FRM_DAT_T]));
                check_value("sd_dat_o",   8'(sd_dat_o),   8'(x[`SD_FRM_DAT_LSB +: 4]));
                check_value("locked_o",   8'(locked_o),   8'h01);
                @(negedge txclk_div);
            end
        end
    endtask

    task automatic test_rotation(input int r);
        bit ok;
        int i;
        lock_link(r, ok);
        if (ok) begin
            repeat (2) @(negedge txclk_div);
            for (i = 0; i < ECHO_CYCLES; i++) begin
                check_value("tx_clk_word_o", tx_clk_word_o, `LINK_TRAIN_PATTERN);
                @(negedge txclk_div);
            end
            test_data_alignment(r);
        end
    endtask

    // Random clock lane words after lock, offset must stay frozen
    task automatic test_sticky_lock();
        logic [7:0] hist [0:STICKY_WORDS + DATA_LAT];
        bit         ok;
        int         r;
        int         k;
        int         i;
        r = 3;
        k = (8 - r) % 8;                     // Offset that undoes rotation r
        lock_link(r, ok);
        if (ok) begin
            hist[0] = rotate_left(`LINK_TRAIN_PATTERN, r);
            for (i = 1; i <= STICKY_WORDS + DATA_LAT; i++) begin
                if (i >= 3)                  // Window at edge i-2, echoed one edge later
                    check_value("tx_clk_word_o", tx_clk_word_o,
                                slip_window(hist[i - 3], hist[i - 2], k));
                check_value("locked_o", 8'(locked_o), 8'h01);
                if (i <= STICKY_WORDS) begin
                    hist[i] = rand_byte();
                    while (rotate_left(hist[i], k) == `LINK_TRAIN_PATTERN)
                        hist[i] = rand_byte();
                end else begin
                    hist[i] = hist[STICKY_WORDS];     // Hold the last word to flush
                end
                rx_clk_word_i = hist[i];
                @(negedge txclk_div);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        txclk_div   = 1'b0;
        rst         = 1'b0;
        error_count = 0;
        check_count = 0;
        drive_idle();
        void'($urandom(RNG_SEED));

        test_reset_values();
        test_frame_packing();
        for (int r = 0; r < 8; r++)
            test_rotation(r);
        test_sticky_lock();

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not complete",
                 WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
